// File: rtl/regCorePkg.sv
package regCorePkg;

        // ##################################################
        // Widths
        // ##################################################

        localparam int DataWidth   = 16;        // One register word.
        localparam int RegIdxWidth = 4;         // Sixteen registers.

        // ##################################################
        // Instruction format
        // ##################################################

        // Codes 10 to 15 are reserved and leave all state untouched.
        typedef enum logic [3:0] {
                Add = 4'd0,
                Sub = 4'd1,
                Xor = 4'd2,
                And = 4'd3,
                Or  = 4'd4,
                Sll = 4'd5,
                Sra = 4'd6,
                Ror = 4'd7,
                Llb = 4'd8,
                Lhb = 4'd9
        } opcodeT;

        // For shifts rt is the amount. For byte loads {rs, rt} is the immediate
        // and rd is both source and destination.
        typedef struct packed {
                opcodeT                 opcode;
                logic [RegIdxWidth-1:0] rd;
                logic [RegIdxWidth-1:0] rs;
                logic [RegIdxWidth-1:0] rt;
        } instrT;

        typedef struct packed {
                logic zero;
                logic overflow;
                logic negative;
        } flagsT;

        typedef struct packed {
                logic [RegIdxWidth-1:0] dst;
                logic [DataWidth-1:0]   value;
                flagsT                  flags;
        } resultT;

endpackage

// File: rtl/registerFile.sv
`timescale 1ns/1ns

module registerFile (
        input  logic                                clk,
        input  logic                                reset,
        input  logic [regCorePkg::RegIdxWidth-1:0]  readIdx1,
        input  logic [regCorePkg::RegIdxWidth-1:0]  readIdx2,
        input  logic                                writeEnable,
        input  logic [regCorePkg::RegIdxWidth-1:0]  writeIdx,
        input  logic [regCorePkg::DataWidth-1:0]    writeData,
        output logic [regCorePkg::DataWidth-1:0]    readData1,
        output logic [regCorePkg::DataWidth-1:0]    readData2
);

        localparam int NumRegs = 1 << regCorePkg::RegIdxWidth;

        // Register 0 is hardwired, so storage and strobes start at 1.
        logic [NumRegs-1:1]                 writeStrobe;
        logic [regCorePkg::DataWidth-1:0]   words [1:NumRegs-1];

        // ##################################################
        // Write decode
        // ##################################################

        always_comb begin
                writeStrobe = '0;
                if (writeEnable && writeIdx != '0) begin
                        writeStrobe[writeIdx] = 1'b1;   // A write to register 0 is dropped.
                end
        end

        // ##################################################
        // Storage
        // ##################################################

        genvar i;
        generate
                for (i = 1; i < NumRegs; i++) begin : gReg
                        always_ff @(posedge clk) begin
                                if (reset) begin
                                        words[i] <= '0;
                                end else if (writeStrobe[i]) begin
                                        words[i] <= writeData;
                                end
                        end
                end
        endgenerate

        // Both read ports are plain muxes on the index, and index 0 reads zero.
        // With one instruction in flight a read never races a write, so no bypass.
        assign readData1 = (readIdx1 == '0) ? '0 : words[readIdx1];
        assign readData2 = (readIdx2 == '0) ? '0 : words[readIdx2];

endmodule

// File: rtl/aluUnit.sv
`timescale 1ns/1ns

module aluUnit (
        input  regCorePkg::instrT                   instr,
        input  logic [regCorePkg::DataWidth-1:0]    operandA,
        input  logic [regCorePkg::DataWidth-1:0]    operandB,
        input  regCorePkg::flagsT                   flags,
        output logic [regCorePkg::DataWidth-1:0]    aluValue,
        output logic                                aluWrite,
        output regCorePkg::flagsT                   aluFlags
);

        localparam int Msb = regCorePkg::DataWidth - 1;

        logic [Msb:0]                       sum;
        logic [Msb:0]                       diff;
        logic [Msb:0]                       satValue;
        logic [2*regCorePkg::DataWidth-1:0] doubled;
        logic [7:0]                         imm8;
        logic                               sumOverflow;
        logic                               diffOverflow;
        logic                               updZero;
        logic                               updSign;

        assign imm8 = {instr.rs, instr.rt};
        assign sum  = operandA + operandB;
        assign diff = operandA - operandB;

        // Signed overflow shows up as a sign flip that the operands cannot explain.
        assign sumOverflow  = (operandA[Msb] == operandB[Msb]) && (sum[Msb] != operandA[Msb]);
        assign diffOverflow = (operandA[Msb] != operandB[Msb]) && (diff[Msb] != operandA[Msb]);

        // On overflow the true result lies beyond the limit on operandA's side.
        assign satValue = operandA[Msb] ? {1'b1, {Msb{1'b0}}} : {1'b0, {Msb{1'b1}}};

        assign doubled = {operandA, operandA} >> instr.rt;     // Rotate by shifting a copy.

        always_comb begin
                aluValue = '0;
                aluWrite = 1'b1;
                aluFlags = flags;
                updZero  = 1'b0;
                updSign  = 1'b0;
                case (instr.opcode)
                        regCorePkg::Add: begin
                                aluValue          = sumOverflow ? satValue : sum;
                                aluFlags.overflow = sumOverflow;
                                updZero           = 1'b1;
                                updSign           = 1'b1;
                        end
                        regCorePkg::Sub: begin
                                aluValue          = diffOverflow ? satValue : diff;
                                aluFlags.overflow = diffOverflow;
                                updZero           = 1'b1;
                                updSign           = 1'b1;
                        end
                        regCorePkg::Xor: begin
                                aluValue = operandA ^ operandB;
                                updZero  = 1'b1;
                        end
                        regCorePkg::And: begin
                                aluValue = operandA & operandB;
                                updZero  = 1'b1;
                        end
                        regCorePkg::Or: begin
                                aluValue = operandA | operandB;
                                updZero  = 1'b1;
                        end
                        regCorePkg::Sll: begin
                                aluValue = operandA << instr.rt;
                                updZero  = 1'b1;
                        end
                        regCorePkg::Sra: begin
                                aluValue = $signed(operandA) >>> instr.rt;
                                updZero  = 1'b1;
                        end
                        regCorePkg::Ror: begin
                                aluValue = doubled[Msb:0];
                                updZero  = 1'b1;
                        end
                        regCorePkg::Llb: aluValue = {operandA[Msb:8], imm8};
                        regCorePkg::Lhb: aluValue = {imm8, operandA[7:0]};
                        default: aluWrite = 1'b0;       // Reserved, value stays zero.
                endcase

                if (updZero) begin
                        aluFlags.zero = (aluValue == '0);
                end
                if (updSign) begin
                        aluFlags.negative = aluValue[Msb];
                end
        end

endmodule

// File: rtl/executeSequencer.sv
`timescale 1ns/1ns

module executeSequencer (
        input  logic                                clk,
        input  logic                                reset,
        input  regCorePkg::instrT                   instr,
        input  logic                                instrReq,
        input  logic                                resultAck,
        input  logic [regCorePkg::DataWidth-1:0]    aluValue,
        input  logic                                aluWrite,
        input  regCorePkg::flagsT                   aluFlags,
        output logic                                instrAck,
        output logic                                resultReq,
        output regCorePkg::resultT                  result,
        output regCorePkg::instrT                   curInstr,
        output regCorePkg::flagsT                   flags,
        output logic [regCorePkg::RegIdxWidth-1:0]  readIdx1,
        output logic [regCorePkg::RegIdxWidth-1:0]  readIdx2,
        output logic                                writeEnable,
        output logic [regCorePkg::RegIdxWidth-1:0]  writeIdx,
        output logic [regCorePkg::DataWidth-1:0]    writeData
);

        typedef enum logic [1:0] {
                Idle,
                Execute,
                Respond
        } stateT;

        stateT state;
        logic  byteLoad;

        // ##################################################
        // Control FSM
        // ##################################################

        always_ff @(posedge clk) begin
                if (reset) begin
                        state     <= Idle;
                        instrAck  <= 1'b0;
                        resultReq <= 1'b0;
                        flags     <= '0;
                end else begin
                        case (state)
                                Idle: begin
                                        if (instrReq) begin
                                                state <= Execute;
                                        end
                                end
                                Execute: begin
                                        flags     <= aluFlags;
                                        instrAck  <= 1'b1;
                                        resultReq <= 1'b1;
                                        state     <= Respond;
                                end
                                Respond: begin
                                        // The two channels finish on their own schedules.
                                        if (resultReq && resultAck) begin
                                                resultReq <= 1'b0;
                                        end
                                        if (instrAck && !instrReq) begin
                                                instrAck <= 1'b0;
                                        end
                                        if (!resultReq && !instrAck && !resultAck) begin
                                                state <= Idle;
                                        end
                                end
                                default: state <= Idle;
                        endcase
                end
        end

        // ##################################################
        // Instruction and result holding
        // ##################################################

        always_ff @(posedge clk) begin
                if (state == Idle && instrReq) begin
                        curInstr <= instr;
                end
                if (state == Execute) begin
                        result.dst   <= curInstr.rd;
                        result.value <= aluValue;      // Held until the next Execute.
                        result.flags <= aluFlags;
                end
        end

        // Byte loads merge into rd, so rd is the first operand there.
        assign byteLoad = (curInstr.opcode == regCorePkg::Llb) ||
                          (curInstr.opcode == regCorePkg::Lhb);

        assign readIdx1 = byteLoad ? curInstr.rd : curInstr.rs;
        assign readIdx2 = curInstr.rt;

        assign writeEnable = (state == Execute) && aluWrite;
        assign writeIdx    = curInstr.rd;
        assign writeData   = aluValue;

endmodule

// File: rtl/regCore.sv
`timescale 1ns/1ns

module regCore (
        input  logic                clk,
        input  logic                reset,
        input  regCorePkg::instrT   instr,
        input  logic                instrReq,
        input  logic                resultAck,
        output logic                instrAck,
        output logic                resultReq,
        output regCorePkg::resultT  result
);

        regCorePkg::instrT                  curInstr;
        regCorePkg::flagsT                  flags;
        regCorePkg::flagsT                  aluFlags;
        logic [regCorePkg::RegIdxWidth-1:0] readIdx1;
        logic [regCorePkg::RegIdxWidth-1:0] readIdx2;
        logic [regCorePkg::RegIdxWidth-1:0] writeIdx;
        logic [regCorePkg::DataWidth-1:0]   readData1;
        logic [regCorePkg::DataWidth-1:0]   readData2;
        logic [regCorePkg::DataWidth-1:0]   writeData;
        logic [regCorePkg::DataWidth-1:0]   aluValue;
        logic                               aluWrite;
        logic                               writeEnable;

        executeSequencer sequencer (
                .clk         (clk),
                .reset       (reset),
                .instr       (instr),
                .instrReq    (instrReq),
                .resultAck   (resultAck),
                .aluValue    (aluValue),
                .aluWrite    (aluWrite),
                .aluFlags    (aluFlags),
                .instrAck    (instrAck),
                .resultReq   (resultReq),
                .result      (result),
                .curInstr    (curInstr),
                .flags       (flags),
                .readIdx1    (readIdx1),
                .readIdx2    (readIdx2),
                .writeEnable (writeEnable),
                .writeIdx    (writeIdx),
                .writeData   (writeData)
        );

        registerFile regFile (
                .clk         (clk),
                .reset       (reset),
                .readIdx1    (readIdx1),
                .readIdx2    (readIdx2),
                .writeEnable (writeEnable),
                .writeIdx    (writeIdx),
                .writeData   (writeData),
                .readData1   (readData1),
                .readData2   (readData2)
        );

        aluUnit alu (
                .instr       (curInstr),
                .operandA    (readData1),
                .operandB    (readData2),
                .flags       (flags),
                .aluValue    (aluValue),
                .aluWrite    (aluWrite),
                .aluFlags    (aluFlags)
        );

endmodule

// File: tb/regCore_chk.sv
`timescale 1ns/1ns

module regCore_chk (
        input logic                clk,
        input logic                reset,
        input logic                instrReq,
        input logic                instrAck,
        input logic                resultReq,
        input logic                resultAck,
        input regCorePkg::resultT  result
);

        // ##################################################
        // Handshake rules
        // ##################################################

        // Both outputs are cleared by the first edge in reset.
        resetQuiet: assert property (@(posedge clk)
                reset |=> (!instrAck && !resultReq))
                else $error("instrAck or resultReq high during reset");

        resultHeld: assert property (@(posedge clk) disable iff (reset)
                resultReq |=> (!resultReq || $stable(result)))
                else $error("result changed while resultReq was high");

        // resultReq may only fall after resultAck has been seen.
        reqUntilAck: assert property (@(posedge clk) disable iff (reset)
                (resultReq && !resultAck) |=> resultReq)
                else $error("resultReq dropped before resultAck");

        ackWhileReq: assert property (@(posedge clk) disable iff (reset)
                (instrAck && instrReq) |=> instrAck)
                else $error("instrAck fell while instrReq was still high");

endmodule

bind regCore regCore_chk chk (
        .clk       (clk),
        .reset     (reset),
        .instrReq  (instrReq),
        .instrAck  (instrAck),
        .resultReq (resultReq),
        .resultAck (resultAck),
        .result    (result)
);

// File: tb/regCoreTb.sv
`timescale 1ns/1ns

module regCoreTb;

        localparam int NumSteps   = 27;
        localparam int Timeout    = 200;        // Cycles allowed for any single wait.
        localparam int DriveDelay = 1;

        typedef struct packed {
                regCorePkg::instrT  instr;
                regCorePkg::resultT expected;
        } stepT;

        // ##################################################
        // Instruction table
        // ##################################################

        // Columns: instr, expected dst, expected value, expected flags {zero, overflow, negative}.
        localparam stepT Steps [NumSteps] = '{
                {16'h0123, 4'h1, 16'h0000, 3'b100},     // Add r1, r2, r3 on cleared registers.
                {16'h8234, 4'h2, 16'h0034, 3'b100},     // Llb r2, 34.
                {16'h9212, 4'h2, 16'h1234, 3'b100},     // Lhb r2, 12.
                {16'h9170, 4'h1, 16'h7000, 3'b100},
                {16'h83F0, 4'h3, 16'h00F0, 3'b100},
                {16'h930F, 4'h3, 16'h0FF0, 3'b100},
                {16'h9420, 4'h4, 16'h2000, 3'b100},
                {16'h8601, 4'h6, 16'h0001, 3'b100},
                {16'h9680, 4'h6, 16'h8001, 3'b100},
                {16'h2723, 4'h7, 16'h1DC4, 3'b000},     // Xor r7, r2, r3.
                {16'h3823, 4'h8, 16'h0230, 3'b000},
                {16'h4923, 4'h9, 16'h1FF4, 3'b000},
                {16'h5A24, 4'hA, 16'h2340, 3'b000},     // Sll r10, r2, 4.
                {16'h6B63, 4'hB, 16'hF000, 3'b000},     // Sra keeps negative as it was.
                {16'h7C24, 4'hC, 16'h4123, 3'b000},
                {16'h3D24, 4'hD, 16'h0000, 3'b100},
                {16'h0514, 4'h5, 16'h7FFF, 3'b010},     // 7000 + 2000 saturates.
                {16'h1E62, 4'hE, 16'h8000, 3'b011},     // 8001 - 1234 saturates low.
                {16'h2733, 4'h7, 16'h0000, 3'b111},
                {16'h1F22, 4'hF, 16'h0000, 3'b100},
                {16'h80AB, 4'h0, 16'h00AB, 3'b100},     // Llb r0 reports but does not store.
                {16'h4500, 4'h5, 16'h0000, 3'b100},
                {16'h1932, 4'h9, 16'hFDBC, 3'b001},
                {16'hC923, 4'h9, 16'h0000, 3'b001},     // Reserved opcode.
                {16'h4A90, 4'hA, 16'hFDBC, 3'b001},     // r9 survived the reserved opcode.
                {16'hF123, 4'h1, 16'h0000, 3'b001},
                {16'h4B10, 4'hB, 16'h7000, 3'b001}
        };

        logic               clk;
        logic               reset;
        regCorePkg::instrT  instr;
        logic               instrReq;
        logic               resultAck;
        logic               instrAck;
        logic               resultReq;
        regCorePkg::resultT result;

        integer seed;
        int     errorCount;
        int     timeoutCount;
        int     checkCount;
        int     received;

        regCore dut (
                .clk       (clk),
                .reset     (reset),
                .instr     (instr),
                .instrReq  (instrReq),
                .resultAck (resultAck),
                .instrAck  (instrAck),
                .resultReq (resultReq),
                .result    (result)
        );

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        // ##################################################
        // Handshake waits
        // ##################################################

        task automatic waitInstrAck(input logic level);
                int cycles;
                cycles = 0;
                while (instrAck !== level && cycles < Timeout) begin
                        @(posedge clk);
                        #DriveDelay;
                        cycles++;
                end
                assert (instrAck === level) else begin
                        $display("Timeout: instrAck did not go to %0b within %0d cycles",
                                 level, Timeout);
                        timeoutCount++;
                end
        endtask

        task automatic waitResultReq(input logic level);
                int cycles;
                cycles = 0;
                while (resultReq !== level && cycles < Timeout) begin
                        @(posedge clk);
                        #DriveDelay;
                        cycles++;
                end
                assert (resultReq === level) else begin
                        $display("Timeout: resultReq did not go to %0b within %0d cycles",
                                 level, Timeout);
                        timeoutCount++;
                end
        endtask

        task automatic checkResult(input int idx, input regCorePkg::resultT expected);
                checkCount++;
                assert (result.dst === expected.dst) else begin
                        $display("Fail step %0d: result.dst expected %h, got %h",
                                 idx, expected.dst, result.dst);
                        errorCount++;
                end
                assert (result.value === expected.value) else begin
                        $display("Fail step %0d: result.value expected %h, got %h",
                                 idx, expected.value, result.value);
                        errorCount++;
                end
                assert (result.flags === expected.flags) else begin
                        $display("Fail step %0d: result.flags expected %h, got %h",
                                 idx, expected.flags, result.flags);
                        errorCount++;
                end
        endtask

        // ##################################################
        // Driver and responder
        // ##################################################

        task automatic driveInstructions();
                int   i;
                stepT step;
                for (i = 0; i < NumSteps; i++) begin
                        step = Steps[i];
                        @(posedge clk);
                        #DriveDelay;
                        instr    = step.instr;
                        instrReq = 1'b1;
                        waitInstrAck(1'b1);
                        if (timeoutCount != 0) break;
                        instrReq = 1'b0;
                        waitInstrAck(1'b0);
                        if (timeoutCount != 0) break;
                end
        endtask

        // Results must come back in table order, one per instruction.
        task automatic answerResults();
                int   i;
                int   delay;
                stepT step;
                for (i = 0; i < NumSteps; i++) begin
                        waitResultReq(1'b1);
                        if (timeoutCount != 0) break;
                        delay = {$random(seed)} % 6;    // Back-pressure of 0 to 5 cycles.
                        repeat (delay) begin
                                @(posedge clk);
                                #DriveDelay;
                        end
                        step = Steps[i];
                        checkResult(i, step.expected);
                        received++;
                        resultAck = 1'b1;
                        waitResultReq(1'b0);
                        resultAck = 1'b0;
                        if (timeoutCount != 0) break;
                end
        endtask

        initial begin
                seed         = 74994;
                errorCount   = 0;
                timeoutCount = 0;
                checkCount   = 0;
                received     = 0;
                reset        = 1'b1;
                instr        = '0;
                instrReq     = 1'b0;
                resultAck    = 1'b0;

                repeat (10) @(posedge clk);
                #DriveDelay;
                reset = 1'b0;

                fork
                        driveInstructions();
                        answerResults();
                join

                // A repeated instruction would raise resultReq again here.
                repeat (10) @(posedge clk);
                #DriveDelay;
                assert (resultReq === 1'b0 && instrAck === 1'b0) else begin
                        $display("The core kept handshaking after the last instruction");
                        errorCount++;
                end
                assert (received == NumSteps) else begin
                        $display("Only %0d of %0d results arrived", received, NumSteps);
                        errorCount++;
                end

                $display("Checks: %0d, errors: %0d, timeouts: %0d, results: %0d of %0d",
                         checkCount, errorCount, timeoutCount, received, NumSteps);
                if (errorCount == 0 && timeoutCount == 0) begin
                        $display("All tests passed");
                end else begin
                        $display("Some tests failed");
                end
                $finish;
        end

endmodule

// File: files.f
rtl/regCorePkg.sv
rtl/registerFile.sv
rtl/aluUnit.sv
rtl/executeSequencer.sv
rtl/regCore.sv
tb/regCore_chk.sv
tb/regCoreTb.sv

// File: Makefile
LOG := sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f files.f --top-module regCoreTb -Mdir obj_dir
	./obj_dir/VregCoreTb | tee $(LOG)
	grep -q "All tests passed" $(LOG)

lint:
	verilator --lint-only --timing --assert -f files.f --top-module regCoreTb

clean:
	rm -rf obj_dir $(LOG)
